// ==== rgmii_pkg.sv ====
`default_nettype none

// rgmii line-level coding, shared by capture, delay line, framer and status
package rgmii_pkg;

    // rxd carries one nibble per rxc edge
    localparam int NIBBLE_W = 4;

    // two nibbles per rxc cycle
    localparam int BYTE_W = 2 * NIBBLE_W;

    // in-band status as sent by the phy between frames
    // low nibble: rxd[3] duplex, rxd[2:1] speed, rxd[0] link
    // high nibble repeats the low one on the falling edge
    typedef struct packed {
        // falling-edge copy, compared only
        logic [NIBBLE_W-1:0] echo;
        // 1 = full duplex
        logic                duplex;
        // phy speed code, 3 is reserved
        logic [1:0]          speed;
        // 1 = link up
        logic                link;
    } rx_status_t;

    // one received byte, read as data inside a frame
    // and as status between frames
    typedef union packed {
        logic [BYTE_W-1:0] data;
        rx_status_t        status;
    } rx_byte_u;

endpackage

`default_nettype wire

// ==== frame_pkg.sv ====
`default_nettype none

// byte stream side of the receiver
package frame_pkg;

    // speed codes as the phy sends them in-band
    typedef enum logic [1:0] {
        SPEED_10M   = 2'd0,
        SPEED_100M  = 2'd1,
        SPEED_1000M = 2'd2
    } speed_e;

    // byte delay in front of the framer, gives eof look-ahead
    localparam int DELAY_STAGES = 2;

    // rising-edge sample to registered framer output
    // 1 capture + DELAY_STAGES + 1 framer
    localparam int RX_LATENCY = DELAY_STAGES + 2;

endpackage

`default_nettype wire

// ==== rgmii_rx_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one joined byte per rxc cycle, no back-pressure
interface rgmii_rx_if;

    // both nibbles of the byte
    rgmii_pkg::rx_byte_u valid_byte;
    // rising-edge rx_ctl
    logic                dv;
    // dv xor falling-edge rx_ctl
    logic                err;
    // a complete byte is present this cycle
    logic                strobe;

    // capture side
    modport producer (
        output valid_byte,
        output dv,
        output err,
        output strobe
    );

    // delay line and status decoder
    modport consumer (
        input valid_byte,
        input dv,
        input err,
        input strobe
    );

endinterface

`default_nettype wire

// ==== rgmii_ddr_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module rgmii_ddr_capture (
    input  wire logic                            RXC,
    input  wire logic                            rst_n,
    input  wire logic [rgmii_pkg::NIBBLE_W-1:0]  rxd,
    input  wire logic                            rx_ctl,
    rgmii_rx_if.producer                         rx
);

    // rising-edge half: data bits 3..0 and dv
    logic [rgmii_pkg::NIBBLE_W-1:0] lo_q;
    logic                           dv_q;
    // falling-edge half: data bits 7..4 and dv^err
    logic [rgmii_pkg::NIBBLE_W-1:0] hi_q;
    logic                           ctl_f;
    // set once a full rising/falling pair has been sampled
    logic                           primed;

    // rising-edge nibble, payload only
    always_ff @(posedge RXC) begin
        lo_q <= rxd;
    end

    // falling-edge nibble, payload only
    always_ff @(negedge RXC) begin
        hi_q <= rxd;
    end

    // falling-edge control bit
    always_ff @(negedge RXC or negedge rst_n) begin
        if (!rst_n) begin
            ctl_f <= 1'b0;
        end else begin
            ctl_f <= rx_ctl;
        end
    end

    // join at the next rising edge
    // lo_q still holds the half from the previous rising edge here
    always_ff @(posedge RXC) begin
        rx.valid_byte.data <= {hi_q, lo_q};
    end

    always_ff @(posedge RXC or negedge rst_n) begin
        if (!rst_n) begin
            dv_q      <= 1'b0;
            primed    <= 1'b0;
            rx.dv     <= 1'b0;
            rx.err    <= 1'b0;
            rx.strobe <= 1'b0;
        end else begin
            dv_q      <= rx_ctl;
            primed    <= 1'b1;
            rx.dv     <= dv_q;
            // falling edge carries dv xor err
            rx.err    <= dv_q ^ ctl_f;
            // first pair after reset is incomplete
            rx.strobe <= primed;
        end
    end

    // no byte may leave capture while the link side is held in reset
    a_no_strobe_in_reset : assert property (
        @(posedge RXC) !rst_n |-> !rx.strobe
    );

endmodule

`default_nettype wire

// ==== rx_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_delay_line (
    input  wire logic           RXC,
    input  wire logic           rst_n,
    rgmii_rx_if.consumer        rx,
    output rgmii_pkg::rx_byte_u byte_d,
    output logic                dv_d,
    output logic                err_d,
    output logic                next_dv
);

    localparam int LAST = frame_pkg::DELAY_STAGES - 1;

    // stage 0 takes the interface, stage LAST feeds the framer
    rgmii_pkg::rx_byte_u                 byte_sr [frame_pkg::DELAY_STAGES];
    logic [frame_pkg::DELAY_STAGES-1:0]  dv_sr;
    logic [frame_pkg::DELAY_STAGES-1:0]  err_sr;

    // byte payload, no reset
    always_ff @(posedge RXC) begin
        if (rx.strobe) begin
            byte_sr[0] <= rx.valid_byte;
            for (int i = 1; i < frame_pkg::DELAY_STAGES; i++) begin
                byte_sr[i] <= byte_sr[i-1];
            end
        end
    end

    // flags shift with the byte
    always_ff @(posedge RXC or negedge rst_n) begin
        if (!rst_n) begin
            dv_sr  <= '0;
            err_sr <= '0;
        end else if (rx.strobe) begin
            dv_sr  <= {dv_sr[LAST-1:0], rx.dv};
            err_sr <= {err_sr[LAST-1:0], rx.err};
        end
    end

    assign byte_d  = byte_sr[LAST];
    assign dv_d    = dv_sr[LAST];
    assign err_d   = err_sr[LAST];
    // dv of the byte right behind the output one
    assign next_dv = dv_sr[LAST-1];

    // pipeline stalls with the capture strobe
    a_dv_hold : assert property (
        @(posedge RXC) disable iff (!rst_n)
        !rx.strobe |=> $stable(dv_d)
    );

endmodule

`default_nettype wire

// ==== rx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_framer (
    input  wire logic                 RXC,
    input  wire logic                 rst_n,
    input  wire rgmii_pkg::rx_byte_u  byte_d,
    input  wire logic                 dv_d,
    input  wire logic                 err_d,
    input  wire logic                 next_dv,
    output logic [7:0]                data_out,
    output logic                      ena,
    output logic                      sof,
    output logic                      eof,
    output logic                      rx_dv,
    output logic                      rx_err
);

    // dv of the byte before the current one
    logic dv_prev;

    // data is only meaningful with ena
    always_ff @(posedge RXC) begin
        data_out <= byte_d.data;
    end

    always_ff @(posedge RXC or negedge rst_n) begin
        if (!rst_n) begin
            dv_prev <= 1'b0;
            ena     <= 1'b0;
            sof     <= 1'b0;
            eof     <= 1'b0;
            rx_dv   <= 1'b0;
            rx_err  <= 1'b0;
        end else begin
            dv_prev <= dv_d;
            ena     <= dv_d;
            rx_dv   <= dv_d;
            // rising dv
            sof     <= dv_d & ~dv_prev;
            // look-ahead, next byte is idle
            eof     <= dv_d & ~next_dv;
            // err outside a frame is in-band signalling, not an error
            rx_err  <= dv_d & err_d;
        end
    end

    a_sof_ena : assert property (
        @(posedge RXC) disable iff (!rst_n) sof |-> ena
    );

    a_eof_ena : assert property (
        @(posedge RXC) disable iff (!rst_n) eof |-> ena
    );

    // every open frame closes before the next one starts
    a_sof_eof_pair : assert property (
        @(posedge RXC) disable iff (!rst_n)
        (sof && !eof) |=> (!sof until eof)
    );

endmodule

`default_nettype wire

// ==== link_status_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_status_decoder (
    input  wire logic          RXC,
    input  wire logic          rst_n,
    rgmii_rx_if.consumer       rx,
    output logic               link_up,
    output logic               duplex,
    output frame_pkg::speed_e  speed
);

    // status view of the interface byte
    rgmii_pkg::rx_status_t st;
    // idle byte that is neither false carrier nor carrier extension
    logic                  idle;
    // both nibbles agree
    logic                  match;
    logic                  accept;

    assign st     = rx.valid_byte.status;
    assign idle   = rx.strobe & ~rx.dv & ~rx.err;
    assign match  = (st.echo == {st.duplex, st.speed, st.link});
    assign accept = idle & match;

    // hold last good status on any rejected byte
    always_ff @(posedge RXC or negedge rst_n) begin
        if (!rst_n) begin
            link_up <= 1'b0;
            duplex  <= 1'b0;
            speed   <= frame_pkg::SPEED_10M;
        end else if (accept) begin
            link_up <= st.link;
            duplex  <= st.duplex;
            speed   <= frame_pkg::speed_e'(st.speed);
        end
    end

    // the phy never announces the reserved speed code
    a_speed_code : assert property (
        @(posedge RXC) disable iff (!rst_n) speed != 2'd3
    );

endmodule

`default_nettype wire

// ==== rgmii_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module rgmii_rx (
    input  wire logic                            RXC,
    input  wire logic                            rst_n,
    input  wire logic [rgmii_pkg::NIBBLE_W-1:0]  rxd,
    input  wire logic                            rx_ctl,
    output logic [7:0]                           data_out,
    output logic                                 ena,
    output logic                                 sof,
    output logic                                 eof,
    output logic                                 rx_dv,
    output logic                                 rx_err,
    output logic                                 link_up,
    output logic                                 duplex,
    output frame_pkg::speed_e                    speed
);

    // capture to delay line and status decoder
    rgmii_rx_if rx_if ();

    // delayed stream to the framer
    rgmii_pkg::rx_byte_u byte_d;
    logic                dv_d;
    logic                err_d;
    logic                next_dv;

    rgmii_ddr_capture u_capture (
        .RXC    (RXC),
        .rst_n  (rst_n),
        .rxd    (rxd),
        .rx_ctl (rx_ctl),
        .rx     (rx_if.producer)
    );

    rx_delay_line u_delay (
        .RXC     (RXC),
        .rst_n   (rst_n),
        .rx      (rx_if.consumer),
        .byte_d  (byte_d),
        .dv_d    (dv_d),
        .err_d   (err_d),
        .next_dv (next_dv)
    );

    rx_framer u_framer (
        .RXC      (RXC),
        .rst_n    (rst_n),
        .byte_d   (byte_d),
        .dv_d     (dv_d),
        .err_d    (err_d),
        .next_dv  (next_dv),
        .data_out (data_out),
        .ena      (ena),
        .sof      (sof),
        .eof      (eof),
        .rx_dv    (rx_dv),
        .rx_err   (rx_err)
    );

    // taps the interface directly, status needs no look-ahead
    link_status_decoder u_status (
        .RXC     (RXC),
        .rst_n   (rst_n),
        .rx      (rx_if.consumer),
        .link_up (link_up),
        .duplex  (duplex),
        .speed   (speed)
    );

endmodule

`default_nettype wire

// ==== tb_rgmii_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rgmii_rx;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    // bytes inside frames and idle bytes between them over all tests
    localparam int FRAME_BYTES  = 16 + 1 + 4 + 5 + 10 + 8 + 1 + 3 + 8;
    localparam int GAP_BYTES    = 4 + 6 + 1 + 1 + 6 + 1 + 6 + 4 + 1 + 2 + 4 + 1 + 6 + 3 + 8;
    localparam int MARGIN       = 64;
    localparam int WATCHDOG_NS  =
        (FRAME_BYTES + GAP_BYTES + 2 * RESET_CYCLES + MARGIN) * CLK_PERIOD;

    logic                           RXC;
    logic                           rst_n;
    logic [rgmii_pkg::NIBBLE_W-1:0] rxd;
    logic                           rx_ctl;
    logic [7:0]                     data_out;
    logic                           ena;
    logic                           sof;
    logic                           eof;
    logic                           rx_dv;
    logic                           rx_err;
    logic                           link_up;
    logic                           duplex;
    frame_pkg::speed_e              speed;

    int          errors = 0;
    // rising edges seen so far
    int          cyc = 0;
    logic [31:0] lfsr = 32'he1bb_e26b;
    // byte sent between frames and read as in-band status
    logic [7:0]  idle_byte = 8'h00;

    // expected data, {sof, eof, err} and output edge per byte
    logic [7:0]  exp_data [$];
    logic [2:0]  exp_flags [$];
    int          exp_edge [$];

    rgmii_rx dut (
        .RXC      (RXC),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .rx_ctl   (rx_ctl),
        .data_out (data_out),
        .ena      (ena),
        .sof      (sof),
        .eof      (eof),
        .rx_dv    (rx_dv),
        .rx_err   (rx_err),
        .link_up  (link_up),
        .duplex   (duplex),
        .speed    (speed)
    );

    initial begin
        RXC = 1'b0;
        forever #(CLK_PERIOD / 2) RXC = ~RXC;
    end

    always @(posedge RXC) begin
        cyc <= cyc + 1;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per payload bit
    task automatic get_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);
            b[k] = lfsr[0];
        end
    endtask

    // center-aligned ddr with each half set up half a period before its sampling edge
    // returns just after the rising edge that samples the low nibble
    task automatic send_byte(input logic [7:0] b, input logic dv, input logic er);
        @(negedge RXC);
        rxd    <= b[3:0];
        rx_ctl <= dv;
        @(posedge RXC);
        rxd    <= b[7:4];
        rx_ctl <= dv ^ er;
    endtask

    task automatic send_idle(input int n);
        repeat (n) send_byte(idle_byte, 1'b0, 1'b0);
    endtask

    task automatic send_frame_byte(input logic [7:0] b, input logic first,
                                   input logic last, input logic er);
        send_byte(b, 1'b1, er);
        exp_data.push_back(b);
        exp_flags.push_back({first, last, er});
        // cyc still holds the count before the sampling edge here
        exp_edge.push_back(cyc + frame_pkg::RX_LATENCY);
    endtask

    // err_at < 0 means a clean frame
    task automatic send_frame(input int n, input int err_at);
        logic [7:0] b;
        for (int i = 0; i < n; i++) begin
            get_byte(b);
            send_frame_byte(b, i == 0, i == n - 1, i == err_at);
        end
    endtask

    task automatic check_status(input logic l, input logic d, input logic [1:0] s);
        @(negedge RXC);
        check("link_up", link_up, l);
        check("duplex", duplex, d);
        check("speed", speed, s);
    endtask

    // outputs change on the rising edge and are sampled on the falling one
    always @(negedge RXC) begin : monitor
        logic [2:0] f;
        logic       due;
        // control outputs during reset are covered by the reset test
        if (rst_n === 1'b1) begin
            // due when its output edge is the last rising edge, cyc - 1
            due = 1'b0;
            if (exp_edge.size() != 0) begin
                due = (exp_edge[0] == cyc - 1);
            end
            check("ena", ena, due);
            check("rx_dv", rx_dv, due);
            if (due) begin
                f = exp_flags.pop_front();
                exp_edge.delete(0);
                check("data_out", data_out, exp_data.pop_front());
                check("sof", sof, f[2]);
                check("eof", eof, f[1]);
                check("rx_err", rx_err, f[0]);
            end else begin
                check("sof", sof, 1'b0);
                check("eof", eof, 1'b0);
                check("rx_err", rx_err, 1'b0);
            end
        end
    end

    task automatic test_random_frame();
        send_frame(16, -1);
        send_idle(6);
    endtask

    // single byte and then two frames one idle byte apart
    task automatic test_short_frames();
        send_frame(1, -1);
        send_idle(1);
        send_frame(4, -1);
        send_idle(1);
        send_frame(5, -1);
        send_idle(6);
    endtask

    task automatic test_error_byte();
        send_frame(10, 5);
        // false carrier between frames is no receive error
        send_byte(idle_byte, 1'b0, 1'b1);
        send_idle(6);
    endtask

    // 0xdd gives full duplex, 1000M and link up in both nibbles
    task automatic test_inband_status();
        idle_byte = 8'hdd;
        send_idle(4);
        check_status(1'b1, 1'b1, frame_pkg::SPEED_1000M);
        send_frame(8, -1);
        send_idle(1);
        // frame byte that would read as link down, half duplex and 10M
        send_frame_byte(8'h00, 1'b1, 1'b1, 1'b0);
        // the idle byte behind it has not reached the decoder yet
        send_idle(2);
        check_status(1'b1, 1'b1, frame_pkg::SPEED_1000M);
        send_idle(4);
    endtask

    // low nibble says link down and the high nibble disagrees
    task automatic test_bad_status();
        send_byte(8'hdc, 1'b0, 1'b0);
        // the bad byte would land two edges later
        repeat (2) @(posedge RXC);
        check_status(1'b1, 1'b1, frame_pkg::SPEED_1000M);
    endtask

    task automatic test_reset_mid_frame();
        logic [7:0] b;
        send_idle(6);
        // frame start that is cut off before any byte leaves
        repeat (3) begin
            get_byte(b);
            send_byte(b, 1'b1, 1'b0);
        end
        @(posedge RXC);
        rst_n  <= 1'b0;
        rx_ctl <= 1'b0;
        rxd    <= '0;
        repeat (RESET_CYCLES) begin
            @(negedge RXC);
            check("ena/sof/eof/rx_dv/rx_err", {ena, sof, eof, rx_dv, rx_err}, 5'b0);
            check("link_up/duplex/speed", {link_up, duplex, speed}, 4'b0);
        end
        @(posedge RXC);
        rst_n <= 1'b1;
        send_idle(3);
        send_frame(8, -1);
    endtask

    initial begin
        rst_n  = 1'b0;
        rxd    = '0;
        rx_ctl = 1'b0;
        repeat (RESET_CYCLES) @(posedge RXC);
        rst_n <= 1'b1;
        send_idle(4);
        test_random_frame();
        test_short_frames();
        test_error_byte();
        test_inband_status();
        test_bad_status();
        test_reset_mid_frame();
        // drain the pipeline
        send_idle(8);
        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d expected bytes never came out", exp_data.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns, %0d errors", WATCHDOG_NS, errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rgmii_pkg.sv
frame_pkg.sv
rgmii_rx_if.sv
rgmii_ddr_capture.sv
rx_delay_line.sv
rx_framer.sv
link_status_decoder.sv
rgmii_rx.sv
tb_rgmii_rx.sv

// ==== Bender.yml ====
package:
  name: rgmii_rx

sources:
  - files:
      - rgmii_pkg.sv
      - frame_pkg.sv
      - rgmii_rx_if.sv
      - rgmii_ddr_capture.sv
      - rx_delay_line.sv
      - rx_framer.sv
      - link_status_decoder.sv
      - rgmii_rx.sv
  - target: simulation
    files:
      - tb_rgmii_rx.sv
